/* verilog/core_status_defs.svh */
`ifndef CORE_STATUS_DEFS_SVH
`define CORE_STATUS_DEFS_SVH

// ----------------------------------------------------------------------
// Core status subsystem parameters
// ----------------------------------------------------------------------

// Program counter width in bits, all eight digits show it
`define CS_PC_WIDTH 32

// Number of seven-segment digits on the board
`define CS_DIGITS 8

// Clock cycles each digit stays enabled during the scan
`define CS_SCAN_DIV 4

// Program counter value loaded by reset
`define CS_RESET_PC 32'h0000_1000

`endif

/* verilog/core_status_pkg.sv */
`default_nettype none

package core_status_pkg;

  // ----------------------------------------------------------------------
  // Run states of the core
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    ST_RST    = 2'd0,
    ST_NORMAL = 2'd1,
    ST_HALT   = 2'd2,
    ST_ERROR  = 2'd3
  } run_state_e;

  // ----------------------------------------------------------------------
  // Fault kinds
  // ----------------------------------------------------------------------
  // Each value is both the bit in the fault vector and the digit that shows it
  typedef enum logic [1:0] {
    FLT_FETCH  = 2'd0,
    FLT_DECODE = 2'd1,
    FLT_MEM    = 2'd2,
    FLT_BRTYPE = 2'd3
  } fault_e;

endpackage

`default_nettype wire

/* verilog/pc_unit.sv */
`default_nettype none

`include "core_status_defs.svh"

module pc_unit (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    run_i,
  input  wire logic                    step_i,
  input  wire logic                    jump_i,
  input  wire logic [`CS_PC_WIDTH-1:0] jump_addr_i,
  output logic      [`CS_PC_WIDTH-1:0] pc_o,
  output logic                         misalign_o
);

  localparam logic [`CS_PC_WIDTH-1:0] PC_STEP = 4;

  logic jump_aligned;
  logic jump_take;
  logic step_take;

  // Instructions are word aligned, so the two low bits of a target must be zero
  assign jump_aligned = (jump_addr_i[1:0] == 2'b00);

  // Jump wins over step in the same cycle, even when the jump is rejected
  assign jump_take = run_i && jump_i;
  assign step_take = run_i && !jump_i && step_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_o       <= `CS_RESET_PC;
      misalign_o <= 1'b0;
    end else begin
      misalign_o <= jump_take && !jump_aligned;
      if (jump_take) begin
        if (jump_aligned) begin
          pc_o <= jump_addr_i;
        end
      end else if (step_take) begin
        pc_o <= pc_o + PC_STEP;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/core_ctrl.sv */
`default_nettype none

module core_ctrl
  import core_status_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  input  wire logic       halt_i,
  input  wire logic       resume_i,
  input  wire logic [3:0] fault_i,
  input  wire logic       misalign_i,
  output run_state_e      state_o,
  output logic      [3:0] faults_o,
  output logic            run_o
);

  run_state_e state_q;
  run_state_e state_d;
  logic [3:0] fault_in;
  logic       any_fault;
  logic       fault_accept;

  // A misaligned jump target counts as a fetch fault
  always_comb begin
    fault_in            = fault_i;
    fault_in[FLT_FETCH] = fault_i[FLT_FETCH] | misalign_i;
  end

  assign any_fault = |fault_in;

  // Faults are recorded in normal and error, and dropped in halt and reset
  assign fault_accept = (state_q == ST_NORMAL) || (state_q == ST_ERROR);

  // ----------------------------------------------------------------------
  // Run-state FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RST: begin
        state_d = ST_NORMAL;
      end
      ST_NORMAL: begin
        if (any_fault) begin
          state_d = ST_ERROR;
        end else if (halt_i) begin
          state_d = ST_HALT;
        end
      end
      ST_HALT: begin
        if (resume_i) begin
          state_d = ST_NORMAL;
        end
      end
      // Error only leaves through reset
      ST_ERROR: begin
        state_d = ST_ERROR;
      end
      default: begin
        state_d = ST_RST;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= ST_RST;
      faults_o <= 4'b0000;
    end else begin
      state_q <= state_d;
      if (fault_accept) begin
        faults_o <= faults_o | fault_in;
      end
    end
  end

  assign state_o = state_q;
  assign run_o   = (state_q == ST_NORMAL);

endmodule

`default_nettype wire

/* verilog/seg_display.sv */
`default_nettype none

`include "core_status_defs.svh"

module seg_display
  import core_status_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire run_state_e              state_i,
  input  wire logic [`CS_PC_WIDTH-1:0] pc_i,
  input  wire logic [3:0]              faults_i,
  output logic      [7:0]              digits_o [`CS_DIGITS]
);

  // ----------------------------------------------------------------------
  // Glyphs, active low, segment a at bit 7 down to dp at bit 0
  // ----------------------------------------------------------------------
  localparam logic [7:0] SEG_BLANK = 8'hFF;
  localparam logic [7:0] SEG_ERR   = ~8'b1001_0010;

  logic [7:0] digits_d [`CS_DIGITS];

  function automatic logic [7:0] hex_glyph(input logic [3:0] nibble);
    logic [7:0] lit;
    case (nibble)
      4'h0:    lit = 8'b1111_1100;
      4'h1:    lit = 8'b0110_0000;
      4'h2:    lit = 8'b1101_1010;
      4'h3:    lit = 8'b1111_0010;
      4'h4:    lit = 8'b0110_0110;
      4'h5:    lit = 8'b1011_0110;
      4'h6:    lit = 8'b1011_1110;
      4'h7:    lit = 8'b1110_0000;
      4'h8:    lit = 8'b1111_1110;
      4'h9:    lit = 8'b1111_0110;
      4'ha:    lit = 8'b1110_1110;
      4'hb:    lit = 8'b0011_1110;
      4'hc:    lit = 8'b1001_1100;
      4'hd:    lit = 8'b0111_1010;
      4'he:    lit = 8'b1001_1110;
      default: lit = 8'b1000_1110;
    endcase
    // The digits are common anode, so a lit segment is driven low
    return ~lit;
  endfunction

  always_comb begin
    for (int k = 0; k < `CS_DIGITS; k++) begin
      digits_d[k] = SEG_BLANK;
    end

    if (state_i == ST_NORMAL || state_i == ST_HALT) begin
      // Digit 0 carries the least significant nibble
      for (int k = 0; k < `CS_DIGITS; k++) begin
        digits_d[k] = hex_glyph(pc_i[k*4 +: 4]);
      end
    end else begin
      // One digit per fault kind, the upper digits stay blank
      digits_d[FLT_FETCH]  = faults_i[FLT_FETCH]  ? SEG_ERR : SEG_BLANK;
      digits_d[FLT_DECODE] = faults_i[FLT_DECODE] ? SEG_ERR : SEG_BLANK;
      digits_d[FLT_MEM]    = faults_i[FLT_MEM]    ? SEG_ERR : SEG_BLANK;
      digits_d[FLT_BRTYPE] = faults_i[FLT_BRTYPE] ? SEG_ERR : SEG_BLANK;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int k = 0; k < `CS_DIGITS; k++) begin
        digits_o[k] <= SEG_BLANK;
      end
    end else begin
      for (int k = 0; k < `CS_DIGITS; k++) begin
        digits_o[k] <= digits_d[k];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/seg_scan.sv */
`default_nettype none

`include "core_status_defs.svh"

module seg_scan (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic [7:0]            digits_i [`CS_DIGITS],
  output logic      [7:0]            seg_o,
  output logic      [`CS_DIGITS-1:0] an_o
);

  localparam int DIV_W = (`CS_SCAN_DIV > 1) ? $clog2(`CS_SCAN_DIV) : 1;
  localparam int IDX_W = $clog2(`CS_DIGITS);

  localparam logic [DIV_W-1:0]      DIV_LAST = DIV_W'(`CS_SCAN_DIV - 1);
  localparam logic [IDX_W-1:0]      IDX_LAST = IDX_W'(`CS_DIGITS - 1);
  localparam logic [`CS_DIGITS-1:0] AN_ONE   = 1;

  logic [DIV_W-1:0] div_q;
  logic [IDX_W-1:0] idx_q;

  // ----------------------------------------------------------------------
  // Scan counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      div_q <= '0;
      idx_q <= '0;
    end else if (div_q == DIV_LAST) begin
      div_q <= '0;
      idx_q <= (idx_q == IDX_LAST) ? '0 : idx_q + 1'b1;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // Enable and pattern are registered together so they never skew
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      an_o  <= '1;
      seg_o <= 8'hFF;
    end else begin
      an_o  <= ~(AN_ONE << idx_q);
      seg_o <= digits_i[idx_q];
    end
  end

endmodule

`default_nettype wire

/* verilog/core_status_top.sv */
`default_nettype none

`include "core_status_defs.svh"

module core_status_top
  import core_status_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    step_i,
  input  wire logic                    jump_i,
  input  wire logic [`CS_PC_WIDTH-1:0] jump_addr_i,
  input  wire logic                    halt_i,
  input  wire logic                    resume_i,
  input  wire logic [3:0]              fault_i,
  output logic      [7:0]              seg_o,
  output logic      [`CS_DIGITS-1:0]   an_o
);

  run_state_e              state;
  logic [3:0]              faults;
  logic                    run;
  logic                    misalign;
  logic [`CS_PC_WIDTH-1:0] pc;
  logic [7:0]              digits [`CS_DIGITS];

  core_ctrl u_core_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .halt_i     (halt_i),
    .resume_i   (resume_i),
    .fault_i    (fault_i),
    .misalign_i (misalign),
    .state_o    (state),
    .faults_o   (faults),
    .run_o      (run)
  );

  pc_unit u_pc_unit (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .run_i       (run),
    .step_i      (step_i),
    .jump_i      (jump_i),
    .jump_addr_i (jump_addr_i),
    .pc_o        (pc),
    .misalign_o  (misalign)
  );

  seg_display u_seg_display (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .state_i  (state),
    .pc_i     (pc),
    .faults_i (faults),
    .digits_o (digits)
  );

  seg_scan u_seg_scan (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .digits_i (digits),
    .seg_o    (seg_o),
    .an_o     (an_o)
  );

endmodule

`default_nettype wire

/* tb/core_status_tb.sv */
`default_nettype none

`include "core_status_defs.svh"

module core_status_tb
  import core_status_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [3:0] P_NONE   = 4'b0000;
  localparam logic [3:0] P_STEP   = 4'b0001;
  localparam logic [3:0] P_JUMP   = 4'b0010;
  localparam logic [3:0] P_HALT   = 4'b0100;
  localparam logic [3:0] P_RESUME = 4'b1000;
  localparam int SCAN_LIMIT = 3 * `CS_DIGITS * `CS_SCAN_DIV;
  localparam logic [`CS_DIGITS-1:0] DIGIT_ONE = `CS_DIGITS'(1);
  localparam logic [`CS_DIGITS-1:0] DIGIT0_AN = ~DIGIT_ONE;

  // Lit segments a..g,dp from bit 7 down, before the common-anode inversion
  localparam logic [7:0] HEX_LIT [16] = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6,
    8'hBE, 8'hE0, 8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E};
  localparam logic [7:0] ERR_LIT = 8'h92;

  logic                    clk_i;
  logic                    rst_i;
  logic                    step_i;
  logic                    jump_i;
  logic [`CS_PC_WIDTH-1:0] jump_addr_i;
  logic                    halt_i;
  logic                    resume_i;
  logic [3:0]              fault_i;
  logic [7:0]              seg_o;
  logic [`CS_DIGITS-1:0]   an_o;

  run_state_e              model_state;
  logic [`CS_PC_WIDTH-1:0] model_pc;
  logic [3:0]              model_faults;
  logic [7:0]              seen [`CS_DIGITS];
  int checks     = 0;
  int errors     = 0;
  int timeouts   = 0;
  int scan_errs  = 0;
  int fails_mark = 0;

  core_status_top u_core_status_top (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .step_i      (step_i),
    .jump_i      (jump_i),
    .jump_addr_i (jump_addr_i),
    .halt_i      (halt_i),
    .resume_i    (resume_i),
    .fault_i     (fault_i),
    .seg_o       (seg_o),
    .an_o        (an_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model and checking
  // ----------------------------------------------------------------------
  function automatic logic [7:0] expected_digit(input run_state_e st,
      input logic [`CS_PC_WIDTH-1:0] pc, input logic [3:0] flt, input int idx);
    logic [3:0] nib;
    nib = pc[idx*4 +: 4];
    if (st == ST_NORMAL || st == ST_HALT) begin
      return ~HEX_LIT[nib];
    end else if (idx < 4 && flt[idx]) begin
      return ~ERR_LIT;
    end
    return 8'hFF;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Drives one pulse cycle, then applies the control rules to the model
  task automatic pulse(input logic [3:0] ctl, input logic [3:0] flt,
                       input logic [`CS_PC_WIDTH-1:0] addr);
    logic       bad_jump;
    logic [3:0] new_flt;
    @(posedge clk_i);
    #1;
    {resume_i, halt_i, jump_i, step_i} = ctl;
    fault_i     = flt;
    jump_addr_i = addr;
    @(posedge clk_i);
    #1;
    {resume_i, halt_i, jump_i, step_i} = P_NONE;
    fault_i = 4'b0000;
    bad_jump = ctl[1] && (addr[1:0] != 2'b00);
    new_flt = flt;
    new_flt[FLT_FETCH] = flt[FLT_FETCH] | bad_jump;
    case (model_state)
      ST_NORMAL: begin
        if (ctl[1] && !bad_jump) begin
          model_pc = addr;
        end else if (ctl[0] && !ctl[1]) begin
          model_pc = model_pc + 4;
        end
        if (new_flt != 4'b0000) begin
          model_faults = model_faults | new_flt;
          model_state  = ST_ERROR;
        end else if (ctl[2]) begin
          model_state = ST_HALT;
        end
      end
      ST_HALT: begin
        if (ctl[3]) begin
          model_state = ST_NORMAL;
        end
      end
      ST_ERROR: begin
        model_faults = model_faults | flt;
      end
      default: begin
      end
    endcase
  endtask

  // Collects one full scan round, starting at a fresh enable of digit 0
  task automatic sample_scan();
    logic [`CS_DIGITS-1:0] prev_an;
    logic [`CS_DIGITS-1:0] exp_an;
    int digit;
    int held;
    int cycles;
    int err_before;
    err_before = errors;
    digit = -1;
    held = 0;
    cycles = 0;
    @(negedge clk_i);
    prev_an = an_o;
    while (digit < `CS_DIGITS) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > SCAN_LIMIT) begin
        $display("Timeout: no complete scan round within %0d cycles", SCAN_LIMIT);
        timeouts++;
        return;
      end
      check_value("an_o one-hot", $countones(~an_o), 1);
      if (an_o == prev_an) begin
        held++;
      end else if (digit < 0) begin
        if (an_o == DIGIT0_AN) begin
          digit = 0;
          held = 1;
          seen[0] = seg_o;
        end
      end else begin
        check_value("an_o hold cycles", held, `CS_SCAN_DIV);
        digit++;
        held = 1;
        exp_an = ~(DIGIT_ONE << (digit % `CS_DIGITS));
        check_value("an_o", an_o, exp_an);
        if (digit < `CS_DIGITS) begin
          seen[digit] = seg_o;
        end
      end
      prev_an = an_o;
    end
    scan_errs += errors - err_before;
  endtask

  task automatic observe();
    // Program counter, display register and scan register each add an edge
    repeat (3) @(negedge clk_i);
    sample_scan();
    for (int k = 0; k < `CS_DIGITS; k++) begin
      check_value($sformatf("seg_o digit %0d", k), seen[k],
                  expected_digit(model_state, model_pc, model_faults, k));
    end
  endtask

  task automatic finish_test(input int num, input string name);
    int fails;
    fails = errors + timeouts - fails_mark;
    $display("test %0d %s: %0d failures", num, name, fails);
    fails_mark = errors + timeouts;
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    rst_i       = 1'b1;
    step_i      = 1'b0;
    jump_i      = 1'b0;
    jump_addr_i = '0;
    halt_i      = 1'b0;
    resume_i    = 1'b0;
    fault_i     = 4'b0000;
    // The reset state lasts one cycle, long before the first scan is sampled
    model_state  = ST_NORMAL;
    model_pc     = `CS_RESET_PC;
    model_faults = 4'b0000;
    repeat (2) @(posedge clk_i);
    #1;
    check_value("an_o in reset", an_o, {`CS_DIGITS{1'b1}});
    rst_i = 1'b0;
    observe();
    finish_test(1, "reset value");

    repeat (10) pulse(P_STEP, 4'b0000, '0);
    observe();
    finish_test(2, "ten steps");

    pulse(P_JUMP, 4'b0000, 32'hBEEF_C0D4);
    observe();
    repeat (3) pulse(P_STEP, 4'b0000, '0);
    observe();
    finish_test(3, "aligned jump");

    pulse(P_HALT, 4'b0000, '0);
    repeat (3) pulse(P_STEP, 4'b0000, '0);
    observe();
    pulse(P_RESUME, 4'b0000, '0);
    repeat (2) pulse(P_STEP, 4'b0000, '0);
    observe();
    finish_test(4, "halt and resume");

    pulse(P_JUMP, 4'b0000, 32'h0000_3002);
    observe();
    pulse(P_NONE, 4'b0001 << FLT_MEM, '0);
    observe();
    repeat (3) pulse(P_STEP, 4'b0000, '0);
    observe();
    finish_test(5, "fault glyphs");

    $display("test 6 scan order: %0d failures", scan_errs);
    $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/core_status_pkg.sv
verilog/pc_unit.sv
verilog/core_ctrl.sv
verilog/seg_display.sv
verilog/seg_scan.sv
verilog/core_status_top.sv
tb/core_status_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the core status testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f compile.f \
  --top-module core_status_tb \
  -o core_status_sim

./obj_dir/core_status_sim | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "Simulation result: PASS"
else
  echo "Simulation result: FAIL"
  exit 1
fi
